//--- rtl/fabric_settings.svh
`ifndef FABRIC_SETTINGS_SVH
`define FABRIC_SETTINGS_SVH

// Grid size in tiles
`define FABRIC_MX 3
`define FABRIC_MY 2

// One config bit per LUT entry
`define CFG_TILE_BITS 16

// Bus word width
`define CFG_WORD_BITS 32

// Slave base address
`define CFG_BASE_ADDR 32'h3000_0000

// Register offsets from base
`define CFG_REG_DATA 32'h0
`define CFG_REG_CTRL 32'h4
`define CFG_REG_SET 32'h8
`define CFG_REG_STATUS 32'hC

`endif

//--- rtl/fabric_pkg.sv
`include "fabric_settings.svh"

package fabric_pkg;

  // Bus data word
  typedef logic [`CFG_WORD_BITS-1:0] wb_word_t;

  // Bus address
  typedef logic [31:0] wb_addr_t;

  // One bit per column, used for shift strobes and column select
  typedef logic [`FABRIC_MX-1:0] col_mask_t;

  // LUT truth table, bit i is the output for input index i
  typedef logic [`CFG_TILE_BITS-1:0] lut_cfg_t;

  // Shift count within one word
  typedef logic [$clog2(`CFG_WORD_BITS)-1:0] bit_cnt_t;

  // Configurator states
  typedef enum logic [1:0] {
    CFG_IDLE,
    CFG_SHIFT,
    CFG_ACK
  } cfg_state_t;

endpackage

//--- rtl/cfg_bus_if.sv
`timescale 1ns/1ps

interface cfg_bus_if
  import fabric_pkg::*;
  ();

  // Serial config data, bottom of every column chain
  logic cfg_bit;
  // Per-column shift strobes
  col_mask_t shift;
  // Commit shadow chains to active tables
  logic set;
  // Global run enable for tile registers
  logic cen;

  // Configurator FSM
  modport ctrl (
    output shift,
    output set,
    output cen
  );

  // Word serializer, advances on any strobe
  modport src (
    output cfg_bit,
    input  shift
  );

  // Logic tiles only listen
  modport tile (
    input shift,
    input set,
    input cen
  );

endinterface

//--- rtl/cfg_wishbone_fsm.sv
`timescale 1ns/1ps
`include "fabric_settings.svh"

module cfg_wishbone_fsm
  import fabric_pkg::*;
(
  input  logic      wb_clk_i,
  input  logic      reset_i,
  input  logic      wbs_stb_i,
  input  logic      wbs_cyc_i,
  input  logic      wbs_we_i,
  input  wb_addr_t  wbs_addr_i,
  input  wb_word_t  wbs_data_i,
  output logic      wbs_ack_o,
  output wb_word_t  wbs_data_o,
  output logic      load_o,
  output logic      cnt_clear_o,
  input  logic      last_i,
  cfg_bus_if.ctrl   cfg
);

  cfg_state_t state_q;
  logic       cen_q;
  col_mask_t  col_sel_q;
  logic       set_q;
  wb_word_t   rdata_q;
  wb_word_t   rdata_d;
  logic       req;
  logic       hit_data;
  logic       hit_ctrl;
  logic       hit_set;
  logic       hit_status;
  logic       data_wr;

  // New request, only taken while idle
  assign req = wbs_stb_i && wbs_cyc_i && (state_q == CFG_IDLE);

  // Full address match per register, anything else is acked and dropped
  assign hit_data   = wbs_addr_i == wb_addr_t'(`CFG_BASE_ADDR + `CFG_REG_DATA);
  assign hit_ctrl   = wbs_addr_i == wb_addr_t'(`CFG_BASE_ADDR + `CFG_REG_CTRL);
  assign hit_set    = wbs_addr_i == wb_addr_t'(`CFG_BASE_ADDR + `CFG_REG_SET);
  assign hit_status = wbs_addr_i == wb_addr_t'(`CFG_BASE_ADDR + `CFG_REG_STATUS);

  assign data_wr = req && wbs_we_i && hit_data;

  // Word load and count restart share the start of a DATA write
  assign load_o      = data_wr;
  assign cnt_clear_o = data_wr;

  // Main sequencer
  always_ff @(posedge wb_clk_i) begin
    if (reset_i) begin
      state_q <= CFG_IDLE;
      set_q   <= 1'b0;
    end else begin
      case (state_q)
        CFG_IDLE: begin
          if (req) begin
            // No column selected means nothing to shift
            if (data_wr && (col_sel_q != '0)) begin
              state_q <= CFG_SHIFT;
            end else begin
              state_q <= CFG_ACK;
            end
            // Commit strobe lines up with the ack cycle
            set_q <= wbs_we_i && hit_set;
          end
        end
        CFG_SHIFT: begin
          // Counter flags the final bit of the word
          if (last_i) begin
            state_q <= CFG_ACK;
          end
        end
        CFG_ACK: begin
          state_q <= CFG_IDLE;
          set_q   <= 1'b0;
        end
        default: begin
          state_q <= CFG_IDLE;
        end
      endcase
    end
  end

  // CTRL register, bit 0 run enable, upper bits column select
  always_ff @(posedge wb_clk_i) begin
    if (reset_i) begin
      cen_q     <= 1'b0;
      col_sel_q <= '0;
    end else if (req && wbs_we_i && hit_ctrl) begin
      cen_q     <= wbs_data_i[0];
      col_sel_q <= wbs_data_i[`FABRIC_MX:1];
    end
  end

  // Read mux, DATA and SET read as zero
  always_comb begin
    rdata_d = '0;
    if (hit_ctrl) begin
      rdata_d = wb_word_t'({col_sel_q, cen_q});
    end else if (hit_status) begin
      rdata_d = wb_word_t'(cen_q);
    end
  end

  // Read data held through the ack cycle
  always_ff @(posedge wb_clk_i) begin
    if (req) begin
      rdata_q <= rdata_d;
    end
  end

  assign wbs_ack_o  = state_q == CFG_ACK;
  assign wbs_data_o = rdata_q;

  // Strobes only while a word is moving
  assign cfg.shift = (state_q == CFG_SHIFT) ? col_sel_q : '0;
  assign cfg.set   = set_q;
  assign cfg.cen   = cen_q;

  // Ack always answers a request seen the cycle before
  ack_after_request: assert property (@(posedge wb_clk_i) disable iff (reset_i)
    wbs_ack_o |-> $past(wbs_cyc_i && wbs_stb_i));

  // Final bit arrives exactly one word after the request was taken
  shift_lasts_one_word: assert property (@(posedge wb_clk_i) disable iff (reset_i)
    (state_q == CFG_SHIFT && last_i) |->
      ($past(state_q, `CFG_WORD_BITS) == CFG_IDLE) &&
      ($past(state_q, `CFG_WORD_BITS - 1) == CFG_SHIFT));

endmodule

//--- rtl/cfg_shift_counter.sv
`timescale 1ns/1ps
`include "fabric_settings.svh"

module cfg_shift_counter
  import fabric_pkg::*;
(
  input  logic wb_clk_i,
  input  logic reset_i,
  input  logic clear_i,
  input  logic count_en_i,
  output logic last_o
);

  localparam bit_cnt_t LAST_CNT = bit_cnt_t'(`CFG_WORD_BITS - 1);

  bit_cnt_t cnt_q;

  // Shifts done so far in the current word
  always_ff @(posedge wb_clk_i) begin
    if (reset_i || clear_i) begin
      cnt_q <= '0;
    end else if (count_en_i) begin
      // Back to zero after the final bit
      cnt_q <= (cnt_q == LAST_CNT) ? '0 : cnt_q + 1'b1;
    end
  end

  // High during the final shift cycle
  assign last_o = count_en_i && (cnt_q == LAST_CNT);

  // Strobes drop only right after the final bit of a word
  stop_after_last: assert property (@(posedge wb_clk_i) disable iff (reset_i)
    $fell(count_en_i) |-> $past(last_o));

endmodule

//--- rtl/cfg_serializer.sv
`timescale 1ns/1ps

module cfg_serializer
  import fabric_pkg::*;
(
  input  logic     wb_clk_i,
  input  logic     reset_i,
  input  logic     load_i,
  input  wb_word_t data_i,
  cfg_bus_if.src   cfg
);

  wb_word_t word_q;
  logic     advance;

  // Any selected column consumes a bit
  assign advance = |cfg.shift;

  // Word goes out LSB first
  always_ff @(posedge wb_clk_i) begin
    if (reset_i) begin
      word_q <= '0;
    end else if (load_i) begin
      word_q <= data_i;
    end else if (advance) begin
      word_q <= word_q >> 1;
    end
  end

  // Present bit feeds the bottom of every chain
  assign cfg.cfg_bit = word_q[0];

endmodule

//--- rtl/clb_tile.sv
`timescale 1ns/1ps
`include "fabric_settings.svh"

module clb_tile
  import fabric_pkg::*;
#(
  // Column this tile sits in, selects its shift strobe
  parameter int COL = 0
) (
  input  logic     wb_clk_i,
  input  logic     reset_i,
  cfg_bus_if.tile  cfg,
  input  logic     chain_i,
  output logic     chain_o,
  input  logic     south_i,
  input  logic     west_i,
  input  logic     pin_south_i,
  input  logic     pin_west_i,
  output logic     out_o
);

  lut_cfg_t   shadow_q;
  lut_cfg_t   active_q;
  logic       out_q;
  logic       col_shift;
  logic [3:0] lut_idx;

  assign col_shift = cfg.shift[COL];

  // Shadow chain, new bit enters at the top and moves toward bit 0
  always_ff @(posedge wb_clk_i) begin
    if (reset_i) begin
      shadow_q <= '0;
    end else if (col_shift) begin
      shadow_q <= {chain_i, shadow_q[`CFG_TILE_BITS-1:1]};
    end
  end

  // Bit 0 continues to the tile above
  assign chain_o = shadow_q[0];

  // Active table, all tiles commit together
  always_ff @(posedge wb_clk_i) begin
    if (reset_i) begin
      active_q <= '0;
    end else if (cfg.set) begin
      active_q <= shadow_q;
    end
  end

  // LUT address, pins in the upper half
  assign lut_idx = {pin_west_i, pin_south_i, west_i, south_i};

  // Output register frozen while run enable is low
  always_ff @(posedge wb_clk_i) begin
    if (reset_i) begin
      out_q <= 1'b0;
    end else if (cfg.cen) begin
      out_q <= active_q[lut_idx];
    end
  end

  assign out_o = out_q;

  // Commit never overlaps a shift into this column
  set_not_during_shift: assert property (@(posedge wb_clk_i) disable iff (reset_i)
    !(cfg.set && col_shift));

endmodule

//--- rtl/fabric_top.sv
`timescale 1ns/1ps
`include "fabric_settings.svh"

module fabric_top
  import fabric_pkg::*;
(
  input  logic                  wb_clk_i,
  input  logic                  reset_i,
  input  logic                  wbs_stb_i,
  input  logic                  wbs_cyc_i,
  input  logic                  wbs_we_i,
  input  wb_addr_t              wbs_addr_i,
  input  wb_word_t              wbs_data_i,
  output logic                  wbs_ack_o,
  output wb_word_t              wbs_data_o,
  input  col_mask_t             gpio_south_i,
  output col_mask_t             gpio_north_o,
  input  logic [`FABRIC_MY-1:0] gpio_west_i,
  output logic [`FABRIC_MY-1:0] gpio_east_o
);

  cfg_bus_if cfg_bus ();

  logic      ser_load;
  logic      cnt_clear;
  logic      cnt_last;
  // Tile outputs, indexed by row then column
  col_mask_t tile_out [`FABRIC_MY];
  // Shadow chain outputs, top row has no reader
  col_mask_t chain_out [`FABRIC_MY];

  cfg_wishbone_fsm u_fsm (
    .wb_clk_i    (wb_clk_i),
    .reset_i     (reset_i),
    .wbs_stb_i   (wbs_stb_i),
    .wbs_cyc_i   (wbs_cyc_i),
    .wbs_we_i    (wbs_we_i),
    .wbs_addr_i  (wbs_addr_i),
    .wbs_data_i  (wbs_data_i),
    .wbs_ack_o   (wbs_ack_o),
    .wbs_data_o  (wbs_data_o),
    .load_o      (ser_load),
    .cnt_clear_o (cnt_clear),
    .last_i      (cnt_last),
    .cfg         (cfg_bus)
  );

  // Counts every cycle with a live strobe
  cfg_shift_counter u_counter (
    .wb_clk_i   (wb_clk_i),
    .reset_i    (reset_i),
    .clear_i    (cnt_clear),
    .count_en_i (|cfg_bus.shift),
    .last_o     (cnt_last)
  );

  cfg_serializer u_serializer (
    .wb_clk_i (wb_clk_i),
    .reset_i  (reset_i),
    .load_i   (ser_load),
    .data_i   (wbs_data_i),
    .cfg      (cfg_bus)
  );

  // Tile grid, fixed nearest-neighbour routing
  for (genvar x = 0; x < `FABRIC_MX; x++) begin : g_col
    for (genvar y = 0; y < `FABRIC_MY; y++) begin : g_row
      logic chain_in;
      logic south_w;
      logic west_w;

      // Bottom row takes the serial bit and the south pins
      if (y == 0) begin : g_bottom
        assign chain_in = cfg_bus.cfg_bit;
        assign south_w  = gpio_south_i[x];
      end else begin : g_above
        assign chain_in = chain_out[y-1][x];
        assign south_w  = tile_out[y-1][x];
      end

      // West column takes the west pins
      if (x == 0) begin : g_west_edge
        assign west_w = gpio_west_i[y];
      end else begin : g_west_tile
        assign west_w = tile_out[y][x-1];
      end

      clb_tile #(
        .COL (x)
      ) u_tile (
        .wb_clk_i    (wb_clk_i),
        .reset_i     (reset_i),
        .cfg         (cfg_bus),
        .chain_i     (chain_in),
        .chain_o     (chain_out[y][x]),
        .south_i     (south_w),
        .west_i      (west_w),
        .pin_south_i (gpio_south_i[x]),
        .pin_west_i  (gpio_west_i[y]),
        .out_o       (tile_out[y][x])
      );
    end
  end

  // North pins from the top row
  assign gpio_north_o = tile_out[`FABRIC_MY-1];

  // East pins from the last column
  for (genvar y = 0; y < `FABRIC_MY; y++) begin : g_east
    assign gpio_east_o[y] = tile_out[y][`FABRIC_MX-1];
  end

endmodule

//--- test/fabric_tb.sv
`timescale 1ns/1ps
`include "fabric_settings.svh"

module fabric_tb
  import fabric_pkg::*;
();

  localparam int CYCLE_LIMIT   = 4000;
  localparam int ACK_LIMIT     = 64;
  localparam int SETTLE_CYCLES = `FABRIC_MX + `FABRIC_MY + 2;

  // Truth tables for four inputs
  localparam logic [15:0] XOR_TABLE = 16'h6996;
  localparam logic [15:0] AND_TABLE = 16'h8000;

  localparam wb_addr_t ADDR_DATA   = wb_addr_t'(`CFG_BASE_ADDR + `CFG_REG_DATA);
  localparam wb_addr_t ADDR_CTRL   = wb_addr_t'(`CFG_BASE_ADDR + `CFG_REG_CTRL);
  localparam wb_addr_t ADDR_SET    = wb_addr_t'(`CFG_BASE_ADDR + `CFG_REG_SET);
  localparam wb_addr_t ADDR_STATUS = wb_addr_t'(`CFG_BASE_ADDR + `CFG_REG_STATUS);

  logic                  wb_clk;
  logic                  reset;
  logic                  wbs_stb;
  logic                  wbs_cyc;
  logic                  wbs_we;
  wb_addr_t              wbs_addr;
  wb_word_t              wbs_wdata;
  logic                  wbs_ack;
  wb_word_t              wbs_rdata;
  col_mask_t             gpio_south;
  col_mask_t             gpio_north;
  logic [`FABRIC_MY-1:0] gpio_west;
  logic [`FABRIC_MY-1:0] gpio_east;

  integer seed = 93730;
  int     cycle_cnt = 0;

  // Reference model of the grid, row then column
  lut_cfg_t  shadow_m [`FABRIC_MY][`FABRIC_MX];
  lut_cfg_t  active_m [`FABRIC_MY][`FABRIC_MX];
  logic      out_m    [`FABRIC_MY][`FABRIC_MX];
  col_mask_t sel_m;
  logic      cen_m;

  fabric_top DUT (
    .wb_clk_i     (wb_clk),
    .reset_i      (reset),
    .wbs_stb_i    (wbs_stb),
    .wbs_cyc_i    (wbs_cyc),
    .wbs_we_i     (wbs_we),
    .wbs_addr_i   (wbs_addr),
    .wbs_data_i   (wbs_wdata),
    .wbs_ack_o    (wbs_ack),
    .wbs_data_o   (wbs_rdata),
    .gpio_south_i (gpio_south),
    .gpio_north_o (gpio_north),
    .gpio_west_i  (gpio_west),
    .gpio_east_o  (gpio_east)
  );

  initial begin
    wb_clk = 1'b0;
    forever #2 wb_clk = ~wb_clk;
  end

  task automatic abort_run();
    $display("Test failed");
    $fatal(1, "Simulation stopped at first error");
  endtask

  // Global cycle budget
  always @(posedge wb_clk) begin
    cycle_cnt++;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Timeout: run went past %0d cycles", CYCLE_LIMIT);
      abort_run();
    end
  end

  task automatic check_word(input string name, input wb_word_t expected,
                            input wb_word_t actual);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, expected, actual);
      abort_run();
    end
  endtask

  task automatic check_pins(input col_mask_t exp_north, input logic [`FABRIC_MY-1:0] exp_east);
    if (gpio_north !== exp_north) begin
      $display("CHECK FAILED at %0t: gpio_north_o expected %b got %b",
               $time, exp_north, gpio_north);
      abort_run();
    end
    if (gpio_east !== exp_east) begin
      $display("CHECK FAILED at %0t: gpio_east_o expected %b got %b",
               $time, exp_east, gpio_east);
      abort_run();
    end
  endtask

  // Ack sampled mid-cycle, request dropped on the same falling edge
  task automatic wait_ack(input string what);
    int waited;
    waited = 0;
    @(negedge wb_clk);
    while (wbs_ack !== 1'b1) begin
      waited++;
      if (waited > ACK_LIMIT) begin
        $display("No ack within %0d cycles for %s", ACK_LIMIT, what);
        abort_run();
      end else begin
        @(negedge wb_clk);
      end
    end
  endtask

  task automatic wb_write(input wb_addr_t addr, input wb_word_t data);
    @(negedge wb_clk);
    wbs_stb   = 1'b1;
    wbs_cyc   = 1'b1;
    wbs_we    = 1'b1;
    wbs_addr  = addr;
    wbs_wdata = data;
    wait_ack("bus write");
    wbs_stb = 1'b0;
    wbs_cyc = 1'b0;
    wbs_we  = 1'b0;
  endtask

  task automatic wb_read(input wb_addr_t addr, output wb_word_t data);
    @(negedge wb_clk);
    wbs_stb  = 1'b1;
    wbs_cyc  = 1'b1;
    wbs_we   = 1'b0;
    wbs_addr = addr;
    wait_ack("bus read");
    data    = wbs_rdata;
    wbs_stb = 1'b0;
    wbs_cyc = 1'b0;
  endtask

  task automatic set_pins(input col_mask_t south, input logic [`FABRIC_MY-1:0] west);
    @(negedge wb_clk);
    gpio_south = south;
    gpio_west  = west;
  endtask

  task automatic reset_model();
    for (int y = 0; y < `FABRIC_MY; y++) begin
      for (int x = 0; x < `FABRIC_MX; x++) begin
        shadow_m[y][x] = '0;
        active_m[y][x] = '0;
        out_m[y][x]    = 1'b0;
      end
    end
    sel_m = '0;
    cen_m = 1'b0;
  endtask

  // LSB first into the bottom tile, each tile moves toward bit 0
  task automatic shift_model_word(input wb_word_t word);
    logic in_bit;
    for (int x = 0; x < `FABRIC_MX; x++) begin
      if (sel_m[x]) begin
        for (int b = 0; b < `CFG_WORD_BITS; b++) begin
          // Top first so each tile sees the old bit 0 below it
          for (int y = `FABRIC_MY - 1; y >= 0; y--) begin
            in_bit = (y == 0) ? word[b] : shadow_m[y-1][x][0];
            shadow_m[y][x] = {in_bit, shadow_m[y][x][`CFG_TILE_BITS-1:1]};
          end
        end
      end
    end
  endtask

  // Grid rule repeated to its fixed point while running
  task automatic model_pins(output col_mask_t exp_north,
                            output logic [`FABRIC_MY-1:0] exp_east);
    logic changed;
    logic south_b;
    logic west_b;
    logic next_b;
    int   passes;
    changed = cen_m;
    passes  = 0;
    while (changed) begin
      changed = 1'b0;
      for (int y = 0; y < `FABRIC_MY; y++) begin
        for (int x = 0; x < `FABRIC_MX; x++) begin
          south_b = (y == 0) ? gpio_south[x] : out_m[y-1][x];
          west_b  = (x == 0) ? gpio_west[y] : out_m[y][x-1];
          next_b  = active_m[y][x][{gpio_west[y], gpio_south[x], west_b, south_b}];
          if (next_b !== out_m[y][x]) begin
            changed = 1'b1;
          end
          out_m[y][x] = next_b;
        end
      end
      passes++;
      if (passes > `FABRIC_MX + `FABRIC_MY + 1) begin
        $display("Reference model did not settle");
        abort_run();
      end
    end
    for (int x = 0; x < `FABRIC_MX; x++) begin
      exp_north[x] = out_m[`FABRIC_MY-1][x];
    end
    for (int y = 0; y < `FABRIC_MY; y++) begin
      exp_east[y] = out_m[y][`FABRIC_MX-1];
    end
  endtask

  task automatic write_ctrl(input logic cen, input col_mask_t sel);
    wb_write(ADDR_CTRL, (wb_word_t'(sel) << 1) | wb_word_t'(cen));
    cen_m = cen;
    sel_m = sel;
  endtask

  task automatic write_data(input wb_word_t word);
    wb_write(ADDR_DATA, word);
    shift_model_word(word);
  endtask

  task automatic commit_tables();
    wb_write(ADDR_SET, '0);
    for (int y = 0; y < `FABRIC_MY; y++) begin
      for (int x = 0; x < `FABRIC_MX; x++) begin
        active_m[y][x] = shadow_m[y][x];
      end
    end
  endtask

  task automatic settle_and_check();
    col_mask_t             exp_north;
    logic [`FABRIC_MY-1:0] exp_east;
    repeat (SETTLE_CYCLES) @(negedge wb_clk);
    model_pins(exp_north, exp_east);
    check_pins(exp_north, exp_east);
  endtask

  task automatic test_reset_state();
    wb_word_t rd;
    wb_read(ADDR_STATUS, rd);
    check_word("STATUS", '0, rd);
    wb_read(ADDR_CTRL, rd);
    check_word("CTRL", '0, rd);
    check_pins('0, '0);
  endtask

  task automatic test_ctrl_access();
    wb_word_t  rd;
    col_mask_t sel;
    sel = col_mask_t'(5);
    write_ctrl(1'b1, sel);
    wb_read(ADDR_CTRL, rd);
    check_word("CTRL", (wb_word_t'(sel) << 1) | 32'd1, rd);
    wb_read(ADDR_STATUS, rd);
    check_word("STATUS", 32'd1, rd);
    // Write-only registers read as zero
    wb_read(ADDR_DATA, rd);
    check_word("DATA", '0, rd);
    wb_read(ADDR_SET, rd);
    check_word("SET", '0, rd);
    write_ctrl(1'b0, sel);
    wb_read(ADDR_STATUS, rd);
    check_word("STATUS", '0, rd);
  endtask

  task automatic test_xor_and();
    set_pins('1, 2'b10);
    write_ctrl(1'b0, '1);
    // AND table in the upper half ends up in the bottom row
    write_data({AND_TABLE, XOR_TABLE});
    commit_tables();
    write_ctrl(1'b1, '1);
    settle_and_check();
  endtask

  task automatic test_single_column();
    col_mask_t             exp_north;
    logic [`FABRIC_MY-1:0] exp_east;
    model_pins(exp_north, exp_east);
    write_ctrl(1'b1, col_mask_t'(2));
    write_data($random(seed));
    // Shadow only, nothing visible yet
    repeat (SETTLE_CYCLES) @(negedge wb_clk);
    check_pins(exp_north, exp_east);
    commit_tables();
    settle_and_check();
  endtask

  task automatic test_freeze();
    col_mask_t             exp_north;
    logic [`FABRIC_MY-1:0] exp_east;
    model_pins(exp_north, exp_east);
    write_ctrl(1'b0, sel_m);
    set_pins(~gpio_south, ~gpio_west);
    repeat (SETTLE_CYCLES) @(negedge wb_clk);
    check_pins(exp_north, exp_east);
    write_ctrl(1'b1, sel_m);
    settle_and_check();
  endtask

  task automatic test_random_rounds();
    for (int r = 0; r < 10; r++) begin
      for (int x = 0; x < `FABRIC_MX; x++) begin
        write_ctrl(1'b1, col_mask_t'(1) << x);
        write_data($random(seed));
      end
      set_pins(col_mask_t'($random(seed)), 2'($random(seed)));
      commit_tables();
      settle_and_check();
    end
  endtask

  initial begin
    reset      = 1'b1;
    wbs_stb    = 1'b0;
    wbs_cyc    = 1'b0;
    wbs_we     = 1'b0;
    wbs_addr   = '0;
    wbs_wdata  = '0;
    gpio_south = '0;
    gpio_west  = '0;
    reset_model();
    repeat (8) @(posedge wb_clk);
    @(negedge wb_clk);
    reset = 1'b0;

    test_reset_state();
    test_ctrl_access();
    test_xor_and();
    test_single_column();
    test_freeze();
    test_random_rounds();

    $display("Test passed");
    $finish;
  end

endmodule

//--- fabric_top.f
+incdir+rtl
rtl/fabric_pkg.sv
rtl/cfg_bus_if.sv
rtl/cfg_wishbone_fsm.sv
rtl/cfg_shift_counter.sv
rtl/cfg_serializer.sv
rtl/clb_tile.sv
rtl/fabric_top.sv
test/fabric_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := fabric_tb
FILELIST   := fabric_top.f
BUILD_DIR  := obj_dir
VFLAGS     := --binary --timing --assert
LINT_FLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# Exit status of the simulation is the test verdict
run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
